// File: sample_pkg.sv
package sample_pkg;

	localparam int SAMPLE_WIDTH = 16;
	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	// Mode field in the low bits of a host command, seeds sit above it.
	localparam int MODE_WIDTH = 4;
	typedef logic [MODE_WIDTH-1:0] mode_t;

	localparam int CMD_RUN_TABLE = 0;
	localparam int CMD_RUN_TRI = 1;
	localparam int CMD_RUN_RAND = 2;
	localparam int CMD_HALT = 3;

	localparam int PERIOD_WIDTH = 16;
	typedef logic [PERIOD_WIDTH-1:0] period_t;

	// Status word is {period, table_ready}.
	typedef logic [PERIOD_WIDTH:0] status_t;

	localparam sample_t LFSR_TAPS = 16'hB400; // Galois feedback mask.
	localparam sample_t TRI_STEP = 16'h0400;

	localparam int DAC_STAGES = 5;

endpackage

// File: dma_stream_if.sv
`timescale 1ns/10ps

interface dma_stream_if import sample_pkg::*; #(
	parameter int BATCH_SIZE = 4
) ();

	logic [BATCH_SIZE*SAMPLE_WIDTH-1:0] tdata; // One batch per beat.
	logic tvalid;
	logic tlast;
	logic tready;

	modport source (
		output tdata,
		output tvalid,
		output tlast,
		input tready
	);

	modport sink (
		input tdata,
		input tvalid,
		input tlast,
		output tready
	);

endinterface

// File: lfsr.sv
`timescale 1ns/10ps

module lfsr import sample_pkg::*; (
	input logic clk,
	input logic rst,
	input logic load,
	input sample_t seed,
	input logic run,
	output sample_t sample
);

	sample_t state;

	assign sample = state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= 16'h0001;
		end else if (load) begin
			state <= (seed == '0) ? 16'h0001 : seed; // The all-zero state would lock up.
		end else if (run) begin
			state <= (state >> 1) ^ (state[0] ? LFSR_TAPS : '0);
		end
	end

endmodule

// File: tri_wave_gen.sv
`timescale 1ns/10ps

module tri_wave_gen import sample_pkg::*; #(
	parameter int BATCH_SIZE = 4
) (
	input logic clk,
	input logic rst,
	input logic run,
	output sample_t [BATCH_SIZE-1:0] batch
);

	localparam logic [16:0] LANE_STEP = 17'(TRI_STEP);
	localparam logic [16:0] BATCH_STEP = 17'(BATCH_SIZE * TRI_STEP);

	logic [16:0] phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (run) begin
			phase <= phase + BATCH_STEP; // Wraps modulo 2^17.
		end
	end

	// The upper half of the phase range is mirrored, so the ramp folds back down.
	always_comb begin
		logic [16:0] lane_phase;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			lane_phase = phase + 17'(i) * LANE_STEP;
			batch[i] = lane_phase[16] ? ~lane_phase[15:0] : lane_phase[15:0];
		end
	end

	a_phase_holds: assert property (
		@(posedge clk) disable iff (rst)
		!run |=> $stable(phase)
	) else $error("tri_wave_gen phase moved without run");

endmodule

// File: wave_table_player.sv
`timescale 1ns/10ps

module wave_table_player import sample_pkg::*; #(
	parameter int BATCH_SIZE = 4,
	parameter int TABLE_DEPTH = 64
) (
	input logic clk,
	input logic rst,
	input logic halt,
	input logic run,
	dma_stream_if.sink dma,
	output logic table_ready,
	output period_t period,
	output sample_t [BATCH_SIZE-1:0] batch,
	output logic batch_valid
);

	localparam int BATCH_WIDTH = BATCH_SIZE * SAMPLE_WIDTH;
	localparam int ADDR_WIDTH = $clog2(TABLE_DEPTH);

	typedef logic [ADDR_WIDTH-1:0] addr_t;

	logic [BATCH_WIDTH-1:0] table_ram [TABLE_DEPTH];
	addr_t wr_addr;
	addr_t rd_addr;
	logic loading;
	logic beat;

	assign dma.tready = loading;
	assign beat = dma.tvalid && dma.tready;
	assign batch = table_ram[rd_addr];
	assign batch_valid = table_ready && !loading;

	always_ff @(posedge clk) begin
		if (beat) begin
			table_ram[wr_addr] <= dma.tdata;
		end
	end

	// A stream is accepted from the cycle after tvalid is first seen.
	always_ff @(posedge clk) begin
		if (rst) begin
			loading <= 1'b0;
			table_ready <= 1'b0;
			wr_addr <= '0;
			period <= '0;
		end else if (!loading) begin
			if (dma.tvalid) begin
				loading <= 1'b1;
				table_ready <= 1'b0; // The old table is overwritten.
			end
		end else if (beat) begin
			if (dma.tlast) begin
				loading <= 1'b0;
				table_ready <= 1'b1;
				wr_addr <= '0;
				period <= period_t'(wr_addr) + period_t'(1);
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || halt || loading) begin
			rd_addr <= '0;
		end else if (run && batch_valid) begin
			if (period_t'(rd_addr) + period_t'(1) >= period) begin
				rd_addr <= '0; // Wrap after the last loaded beat.
			end else begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	a_table_fits: assert property (
		@(posedge clk) disable iff (rst)
		(beat && !dma.tlast) |-> (wr_addr != addr_t'(TABLE_DEPTH - 1))
	) else $error("DMA stream longer than the wave table");

endmodule

// File: sample_generator.sv
`timescale 1ns/10ps

module sample_generator import sample_pkg::*; #(
	parameter int BATCH_SIZE = 4,
	parameter int TABLE_DEPTH = 64,
	parameter int BS_WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic [MODE_WIDTH+BATCH_SIZE*SAMPLE_WIDTH-1:0] cmd,
	input logic cmd_valid,
	input logic dac_rdy,
	input logic [BS_WIDTH-1:0] burst_size,
	input logic transfer_rdy,
	output status_t status_word,
	output logic status_valid,
	output logic [BATCH_SIZE*SAMPLE_WIDTH-1:0] dac_batch,
	output logic dac_batch_valid,
	dma_stream_if.sink dma
);

	localparam int BATCH_WIDTH = BATCH_SIZE * SAMPLE_WIDTH;

	typedef enum logic {IDLE, HALTED} halt_state_t;

	halt_state_t state;
	mode_t mode;
	logic halt, halt_cmd, set_seeds;
	logic run_rand, run_tri, run_table;
	logic sel_tri, sel_table;
	sample_t [BATCH_SIZE-1:0] rand_seed, rand_batch, tri_batch, table_batch, batch_in;
	logic valid_in;
	logic table_ready, table_valid;
	period_t period;
	status_t status_cur;
	logic [DAC_STAGES-1:0] pipe_valid;
	logic [DAC_STAGES-1:0][BATCH_WIDTH-1:0] pipe_data;
	logic [BS_WIDTH-1:0] burst_cnt;

	for (genvar i = 0; i < BATCH_SIZE; i++) begin : g_lane
		lfsr i_lfsr (
			.clk(clk),
			.rst(rst),
			.load(set_seeds),
			.seed(rand_seed[i]),
			.run(run_rand && dac_rdy && !set_seeds),
			.sample(rand_batch[i])
		);
	end

	// A new command restarts the triangle from phase zero.
	tri_wave_gen #(.BATCH_SIZE(BATCH_SIZE)) i_tri_wave_gen (
		.clk(clk),
		.rst(rst || halt || cmd_valid),
		.run(sel_tri && dac_rdy),
		.batch(tri_batch)
	);

	wave_table_player #(.BATCH_SIZE(BATCH_SIZE), .TABLE_DEPTH(TABLE_DEPTH)) i_wave_table_player (
		.clk(clk),
		.rst(rst),
		.halt(halt || cmd_valid),
		.run(sel_table && dac_rdy),
		.dma(dma),
		.table_ready(table_ready),
		.period(period),
		.batch(table_batch),
		.batch_valid(table_valid)
	);

	assign mode = cmd[MODE_WIDTH-1:0];
	assign halt = halt_cmd || (state == HALTED);
	assign sel_tri = run_tri && !run_rand;
	assign sel_table = run_table && !run_rand && !run_tri;
	assign status_cur = {period, table_ready};
	assign dac_batch = pipe_data[DAC_STAGES-1];
	assign dac_batch_valid = pipe_valid[DAC_STAGES-1] && dac_rdy && !halt;

	always_comb begin
		batch_in = '0;
		valid_in = 1'b0;
		if (run_rand) begin
			batch_in = rand_batch;
			valid_in = !set_seeds; // Seeds are still loading.
		end else if (sel_tri) begin
			batch_in = tri_batch;
			valid_in = 1'b1;
		end else if (sel_table) begin
			batch_in = table_batch;
			valid_in = table_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || halt) begin
			{halt_cmd, run_rand, run_tri, run_table, set_seeds} <= '0;
			rand_seed <= '0;
		end else begin
			set_seeds <= cmd_valid && mode[CMD_RUN_RAND];
			if (cmd_valid) begin
				halt_cmd <= mode[CMD_HALT];
				run_rand <= mode[CMD_RUN_RAND];
				run_tri <= mode[CMD_RUN_TRI];
				run_table <= mode[CMD_RUN_TABLE];
				if (mode[CMD_RUN_RAND]) begin
					rand_seed <= cmd[MODE_WIDTH +: BATCH_WIDTH];
				end
			end
		end
	end

	// Halt drops every batch in flight.
	always_ff @(posedge clk) begin
		if (rst || halt) begin
			pipe_valid <= '0;
		end else if (dac_rdy) begin
			pipe_valid <= {pipe_valid[DAC_STAGES-2:0], valid_in};
		end
	end

	always_ff @(posedge clk) begin
		if (dac_rdy) begin
			pipe_data <= {pipe_data[DAC_STAGES-2:0], batch_in};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			burst_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (halt_cmd) begin
						state <= HALTED;
					end else if (cmd_valid) begin
						burst_cnt <= '0; // Each run command starts a fresh burst.
					end else if ((burst_size != '0) && dac_batch_valid) begin
						if (burst_cnt == burst_size - 1'b1) begin
							state <= HALTED;
						end
						burst_cnt <= burst_cnt + 1'b1;
					end
				end
				HALTED: begin
					if (!pipe_valid[DAC_STAGES-1]) begin
						state <= IDLE;
						burst_cnt <= '0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst || halt) begin
			status_valid <= 1'b0;
			status_word <= '0;
		end else if (!status_valid) begin
			if (status_word != status_cur) begin
				status_word <= status_cur;
				status_valid <= 1'b1;
			end
		end else if (transfer_rdy) begin
			status_valid <= 1'b0;
		end else begin
			status_word <= status_cur; // Keep the pending word current.
		end
	end

	a_status_pending: assert property (
		@(posedge clk) disable iff (rst)
		(status_valid && !transfer_rdy && !halt) |=> status_valid
	) else $error("status_valid dropped before the host took the word");

	a_halt_silences: assert property (
		@(posedge clk) disable iff (rst)
		halt |=> !dac_batch_valid
	) else $error("valid DAC batch right after halt");

endmodule

// File: dac_sample_top.sv
`timescale 1ns/10ps

module dac_sample_top import sample_pkg::*; #(
	parameter int BATCH_SIZE = 4,
	parameter int TABLE_DEPTH = 64,
	parameter int BS_WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic [MODE_WIDTH+BATCH_SIZE*SAMPLE_WIDTH-1:0] cmd,
	input logic cmd_valid,
	input logic dac_rdy,
	input logic [BS_WIDTH-1:0] burst_size,
	input logic transfer_rdy,
	input logic [BATCH_SIZE*SAMPLE_WIDTH-1:0] dma_tdata,
	input logic dma_tvalid,
	input logic dma_tlast,
	output logic dma_tready,
	output status_t status_word,
	output logic status_valid,
	output logic [BATCH_SIZE*SAMPLE_WIDTH-1:0] dac_batch,
	output logic dac_batch_valid
);

	dma_stream_if #(.BATCH_SIZE(BATCH_SIZE)) dma ();

	assign dma.tdata = dma_tdata;
	assign dma.tvalid = dma_tvalid;
	assign dma.tlast = dma_tlast;
	assign dma_tready = dma.tready;

	sample_generator #(
		.BATCH_SIZE(BATCH_SIZE),
		.TABLE_DEPTH(TABLE_DEPTH),
		.BS_WIDTH(BS_WIDTH)
	) i_sample_generator (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.dac_rdy(dac_rdy),
		.burst_size(burst_size),
		.transfer_rdy(transfer_rdy),
		.status_word(status_word),
		.status_valid(status_valid),
		.dac_batch(dac_batch),
		.dac_batch_valid(dac_batch_valid),
		.dma(dma)
	);

endmodule

// File: tb_dac_sample_top.sv
`timescale 1ns/10ps

module tb_dac_sample_top import sample_pkg::*; ();

	localparam int BATCH_SIZE = 4;
	localparam int TABLE_DEPTH = 64;
	localparam int BS_WIDTH = 16;
	localparam int BATCH_W = BATCH_SIZE * SAMPLE_WIDTH;
	localparam int TIMEOUT = 500;
	localparam int NO_SOURCE = -1;
	localparam int TABLE_LEN = 7;
	localparam int BURST_LEN = 6;

	logic clk;
	logic rst;
	logic [MODE_WIDTH+BATCH_W-1:0] cmd;
	logic cmd_valid;
	logic dac_rdy;
	logic [BS_WIDTH-1:0] burst_size;
	logic transfer_rdy;
	logic [BATCH_W-1:0] dma_tdata;
	logic dma_tvalid;
	logic dma_tlast;
	logic dma_tready;
	status_t status_word;
	logic status_valid;
	logic [BATCH_W-1:0] dac_batch;
	logic dac_batch_valid;

	integer seed;
	int errors = 0;
	int checks = 0;
	int timeouts = 0;
	int valid_count = 0;
	int exp_mode;
	int exp_index;
	logic use_gaps;
	logic hold_status;
	status_t held_status;
	sample_t lane_state [BATCH_SIZE];
	logic [BATCH_W-1:0] table_beats [TABLE_DEPTH];

	dac_sample_top #(
		.BATCH_SIZE(BATCH_SIZE),
		.TABLE_DEPTH(TABLE_DEPTH),
		.BS_WIDTH(BS_WIDTH)
	) i_dac_sample_top (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(string name, logic [BATCH_W-1:0] got, logic [BATCH_W-1:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	function automatic sample_t lfsr_next(sample_t s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// Phase is taken modulo 2^17 and the upper half folds back down.
	function automatic sample_t tri_fold(int unsigned index);
		logic [16:0] p;
		p = 17'(index * TRI_STEP);
		return p[16] ? ~p[15:0] : p[15:0];
	endfunction

	function automatic logic [BATCH_W-1:0] expected_batch();
		logic [BATCH_W-1:0] b;
		b = '0;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			if (exp_mode == CMD_RUN_RAND) begin
				b[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lane_state[i];
			end else if (exp_mode == CMD_RUN_TRI) begin
				b[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = tri_fold(exp_index * BATCH_SIZE + i);
			end
		end
		if (exp_mode == CMD_RUN_TABLE) begin
			b = table_beats[exp_index % TABLE_LEN];
		end
		return b;
	endfunction

	function automatic void advance_model();
		exp_index++;
		if (exp_mode == CMD_RUN_RAND) begin
			for (int i = 0; i < BATCH_SIZE; i++) begin
				lane_state[i] = lfsr_next(lane_state[i]);
			end
		end
	endfunction

	task automatic send_command(mode_t mode, logic [BATCH_W-1:0] seeds);
		cmd = {seeds, mode};
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic run_command(int source, logic [BATCH_W-1:0] seeds);
		sample_t lane_seed;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			lane_seed = seeds[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
			lane_state[i] = (lane_seed == '0) ? sample_t'(1) : lane_seed; // Zero would lock the LFSR.
		end
		exp_index = 0;
		exp_mode = source;
		send_command(mode_t'(1 << source), seeds);
	endtask

	task automatic halt_and_flush();
		send_command(mode_t'(1 << CMD_HALT), '0);
		exp_mode = NO_SOURCE;
		repeat (DAC_STAGES + 1) @(negedge clk);
	endtask

	task automatic wait_batches(int count);
		int start;
		int cycles;
		start = valid_count;
		cycles = 0;
		while (valid_count - start < count && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (valid_count - start < count) begin
			timeouts++;
			$display("Timeout: only %0d of %0d valid DAC batches arrived", valid_count - start, count);
		end
	endtask

	task automatic wait_status();
		int cycles;
		cycles = 0;
		while (!status_valid && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!status_valid) begin
			timeouts++;
			$display("Timeout: status_valid never rose after the table load");
		end
	endtask

	task automatic stream_table(int beats);
		int cycles;
		for (int b = 0; b < beats; b++) begin
			dma_tdata = table_beats[b];
			dma_tvalid = 1'b1;
			dma_tlast = (b == beats - 1);
			cycles = 0;
			while (!dma_tready && cycles < TIMEOUT) begin
				@(negedge clk);
				cycles++;
			end
			if (!dma_tready) begin
				timeouts++;
				$display("Timeout: DMA beat %0d was never accepted", b);
			end
			@(negedge clk); // The beat moves at the rising edge in between.
		end
		dma_tvalid = 1'b0;
		dma_tlast = 1'b0;
	endtask

	always @(negedge clk) begin
		if (use_gaps) begin
			dac_rdy = ($random(seed) & 3) != 0; // Stall about one cycle in four.
		end else begin
			dac_rdy = 1'b1;
		end
	end

	// Every valid batch is compared with the model of the running source, in order.
	always @(posedge clk) begin
		logic [BATCH_W-1:0] expected;
		if (!rst && dac_batch_valid) begin
			valid_count++;
			if (exp_mode != NO_SOURCE) begin
				expected = expected_batch();
				check_value("dac_batch", dac_batch, expected);
				advance_model();
			end
		end
	end

	a_valid_needs_source: assert property (
		@(posedge clk) disable iff (rst)
		dac_batch_valid |-> exp_mode != NO_SOURCE
	) else begin
		errors++;
		$display("Valid DAC batch at %0t while no source should be running", $time);
	end

	a_status_held: assert property (
		@(posedge clk) disable iff (rst)
		hold_status |-> (status_valid && status_word == held_status)
	) else begin
		errors++;
		$display("[ERROR] %0t status_word: got %0h (valid %0b), expected %0h (valid 1)",
			$time, $sampled(status_word), $sampled(status_valid), held_status);
	end

	initial begin
		logic [BATCH_W-1:0] seeds;
		int start;
		seed = 32'h73005cd8;
		rst = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		dac_rdy = 1'b1;
		burst_size = '0;
		transfer_rdy = 1'b0;
		dma_tdata = '0;
		dma_tvalid = 1'b0;
		dma_tlast = 1'b0;
		use_gaps = 1'b0;
		hold_status = 1'b0;
		held_status = '0;
		exp_mode = NO_SOURCE;
		exp_index = 0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		repeat (10) begin
			@(negedge clk);
			check_value("dac_batch_valid", dac_batch_valid, 1'b0);
			check_value("status_valid", status_valid, 1'b0);
			check_value("dma_tready", dma_tready, 1'b0);
		end

		for (int i = 0; i < BATCH_SIZE; i++) begin
			seeds[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_t'($random(seed));
		end
		seeds[SAMPLE_WIDTH +: SAMPLE_WIDTH] = '0; // Lane 1 starts from a zero seed.
		use_gaps = 1'b1;
		run_command(CMD_RUN_RAND, seeds);
		wait_batches(30);
		use_gaps = 1'b0;
		halt_and_flush();

		run_command(CMD_RUN_TRI, '0);
		wait_batches(40); // Past one full triangle period.
		halt_and_flush();

		for (int b = 0; b < TABLE_LEN; b++) begin
			table_beats[b] = {$random(seed), $random(seed)};
		end
		stream_table(TABLE_LEN);
		wait_status();
		check_value("status_word", status_word, {period_t'(TABLE_LEN), 1'b1});
		held_status = {period_t'(TABLE_LEN), 1'b1};
		hold_status = 1'b1;
		repeat (5) @(negedge clk);
		hold_status = 1'b0;
		transfer_rdy = 1'b1;
		@(negedge clk);
		transfer_rdy = 1'b0;
		check_value("status_valid", status_valid, 1'b0);

		use_gaps = 1'b1;
		run_command(CMD_RUN_TABLE, '0);
		wait_batches(2 * TABLE_LEN + 3);
		use_gaps = 1'b0;
		halt_and_flush();

		burst_size = BS_WIDTH'(BURST_LEN);
		start = valid_count;
		run_command(CMD_RUN_TRI, '0);
		wait_batches(BURST_LEN);
		exp_mode = NO_SOURCE;
		repeat (20) @(negedge clk);
		check_value("burst batch count", valid_count - start, BURST_LEN);
		burst_size = '0;
		run_command(CMD_RUN_TRI, '0);
		wait_batches(3);
		halt_and_flush();

		for (int i = 0; i < BATCH_SIZE; i++) begin
			seeds[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_t'($random(seed));
		end
		run_command(CMD_RUN_RAND, seeds);
		wait_batches(8);
		check_value("status_valid", status_valid, 1'b1);
		send_command(mode_t'(1 << CMD_HALT), '0);
		exp_mode = NO_SOURCE;
		@(negedge clk);
		check_value("status_valid", status_valid, 1'b0);
		repeat (DAC_STAGES) @(negedge clk);
		start = valid_count;
		repeat (20) @(negedge clk);
		check_value("batches after halt", valid_count - start, 0);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: build.f
sample_pkg.sv
dma_stream_if.sv
lfsr.sv
tri_wave_gen.sv
wave_table_player.sv
sample_generator.sv
dac_sample_top.sv
tb_dac_sample_top.sv

// File: Bender.yml
package:
  name: dac_sample_top

sources:
  - sample_pkg.sv
  - dma_stream_if.sv
  - lfsr.sv
  - tri_wave_gen.sv
  - wave_table_player.sv
  - sample_generator.sv
  - dac_sample_top.sv
  - target: test
    files:
      - tb_dac_sample_top.sv
